// File: src/dtm_pkg.sv
`default_nettype none

package dtm_pkg;

    // instruction register, 5 bits minimum for a debug transport
    localparam int IR_WIDTH = 5;

    // device id word, top level default
    localparam logic [31:0] IDCODE_VALUE = 32'h12345678;

    // instruction codes, anything else falls back to bypass
    localparam logic [IR_WIDTH-1:0] INSTR_IDCODE = 5'h01;
    localparam logic [IR_WIDTH-1:0] INSTR_BYPASS = 5'h1f;
    localparam logic [IR_WIDTH-1:0] INSTR_DMI    = 5'h11;

    // loaded into ir shift stage on capture
    localparam logic [IR_WIDTH-1:0] IR_CAPTURE = 5'b00001;

    // dmi word layout: addr | data | op
    localparam int ABITS     = 10;
    localparam int DMI_WIDTH = ABITS + 34;

    // op field, outgoing requests
    localparam logic [1:0] OP_NOP   = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_WRITE = 2'd2;

    // op field, returned status
    localparam logic [1:0] OP_SUCCESS = 2'd0;
    localparam logic [1:0] OP_BUSY    = 2'd3;

    // tap state codes
    localparam int STATE_W = 4;
    localparam logic [STATE_W-1:0] TLR        = 4'd0;
    localparam logic [STATE_W-1:0] RUN_IDLE   = 4'd1;
    localparam logic [STATE_W-1:0] SELECT_DR  = 4'd2;
    localparam logic [STATE_W-1:0] CAPTURE_DR = 4'd3;
    localparam logic [STATE_W-1:0] SHIFT_DR   = 4'd4;
    localparam logic [STATE_W-1:0] EXIT1_DR   = 4'd5;
    localparam logic [STATE_W-1:0] PAUSE_DR   = 4'd6;
    localparam logic [STATE_W-1:0] EXIT2_DR   = 4'd7;
    localparam logic [STATE_W-1:0] UPDATE_DR  = 4'd8;
    localparam logic [STATE_W-1:0] SELECT_IR  = 4'd9;
    localparam logic [STATE_W-1:0] CAPTURE_IR = 4'd10;
    localparam logic [STATE_W-1:0] SHIFT_IR   = 4'd11;
    localparam logic [STATE_W-1:0] EXIT1_IR   = 4'd12;
    localparam logic [STATE_W-1:0] PAUSE_IR   = 4'd13;
    localparam logic [STATE_W-1:0] EXIT2_IR   = 4'd14;
    localparam logic [STATE_W-1:0] UPDATE_IR  = 4'd15;

    // shift path sees raw bits, request side sees fields
    typedef union packed {
        logic [DMI_WIDTH-1:0] raw;
        struct packed {
            logic [ABITS-1:0] addr;
            logic [31:0]      data;
            logic [1:0]       op;
        } f;
    } dmi_word_u;

endpackage

`default_nettype wire

// File: src/jtag_sync.sv
`timescale 1ns/1ps
`default_nettype none

module jtag_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic jtag_clk_i,
    input  logic jtag_tms_i,
    input  logic jtag_tdi_i,
    output logic tck_rise_o,
    output logic tck_fall_o,
    output logic tms_o,
    output logic tdi_o
);

    // first and second synchronizer stages
    logic tck_s1;
    logic tck_s2;
    logic tms_s1;
    logic tms_s2;
    logic tdi_s1;
    logic tdi_s2;
    // last synchronized tck, for edge compare
    logic tck_prev;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            tck_s1     <= 1'b0;
            tck_s2     <= 1'b0;
            tms_s1     <= 1'b0;
            tms_s2     <= 1'b0;
            tdi_s1     <= 1'b0;
            tdi_s2     <= 1'b0;
            tck_prev   <= 1'b0;
            tck_rise_o <= 1'b0;
            tck_fall_o <= 1'b0;
            tms_o      <= 1'b0;
            tdi_o      <= 1'b0;
        end
        else
        begin
            tck_s1     <= jtag_clk_i;
            tck_s2     <= tck_s1;
            tms_s1     <= jtag_tms_i;
            tms_s2     <= tms_s1;
            tdi_s1     <= jtag_tdi_i;
            tdi_s2     <= tdi_s1;
            tck_prev   <= tck_s2;
            // edge register, third clk edge after the pin moves
            tck_rise_o <= tck_s2 & ~tck_prev;
            tck_fall_o <= ~tck_s2 & tck_prev;
            // extra stage so tms/tdi line up with the pulses
            tms_o      <= tms_s2;
            tdi_o      <= tdi_s2;
        end
    end

endmodule

`default_nettype wire

// File: src/tap_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tap_controller (
    input  logic clk,
    input  logic rst_n,
    input  logic tck_rise_i,
    input  logic tms_i,
    output logic capture_dr_o,
    output logic shift_dr_o,
    output logic update_dr_o,
    output logic capture_ir_o,
    output logic shift_ir_o,
    output logic update_ir_o,
    output logic tlr_o,
    output logic shifting_o,
    output logic ir_path_o
);

    logic [dtm_pkg::STATE_W-1:0] state;
    logic [dtm_pkg::STATE_W-1:0] state_nxt;

    // ieee 1149.1 transition table
    always_comb
    begin
        state_nxt = state;
        case (state)
            dtm_pkg::TLR:        state_nxt = tms_i ? dtm_pkg::TLR : dtm_pkg::RUN_IDLE;
            dtm_pkg::RUN_IDLE:   state_nxt = tms_i ? dtm_pkg::SELECT_DR : dtm_pkg::RUN_IDLE;
            dtm_pkg::SELECT_DR:  state_nxt = tms_i ? dtm_pkg::SELECT_IR : dtm_pkg::CAPTURE_DR;
            dtm_pkg::CAPTURE_DR: state_nxt = tms_i ? dtm_pkg::EXIT1_DR : dtm_pkg::SHIFT_DR;
            dtm_pkg::SHIFT_DR:   state_nxt = tms_i ? dtm_pkg::EXIT1_DR : dtm_pkg::SHIFT_DR;
            dtm_pkg::EXIT1_DR:   state_nxt = tms_i ? dtm_pkg::UPDATE_DR : dtm_pkg::PAUSE_DR;
            dtm_pkg::PAUSE_DR:   state_nxt = tms_i ? dtm_pkg::EXIT2_DR : dtm_pkg::PAUSE_DR;
            dtm_pkg::EXIT2_DR:   state_nxt = tms_i ? dtm_pkg::UPDATE_DR : dtm_pkg::SHIFT_DR;
            dtm_pkg::UPDATE_DR:  state_nxt = tms_i ? dtm_pkg::SELECT_DR : dtm_pkg::RUN_IDLE;
            // tms high out of select-ir gives the tlr escape
            dtm_pkg::SELECT_IR:  state_nxt = tms_i ? dtm_pkg::TLR : dtm_pkg::CAPTURE_IR;
            dtm_pkg::CAPTURE_IR: state_nxt = tms_i ? dtm_pkg::EXIT1_IR : dtm_pkg::SHIFT_IR;
            dtm_pkg::SHIFT_IR:   state_nxt = tms_i ? dtm_pkg::EXIT1_IR : dtm_pkg::SHIFT_IR;
            dtm_pkg::EXIT1_IR:   state_nxt = tms_i ? dtm_pkg::UPDATE_IR : dtm_pkg::PAUSE_IR;
            dtm_pkg::PAUSE_IR:   state_nxt = tms_i ? dtm_pkg::EXIT2_IR : dtm_pkg::PAUSE_IR;
            dtm_pkg::EXIT2_IR:   state_nxt = tms_i ? dtm_pkg::UPDATE_IR : dtm_pkg::SHIFT_IR;
            dtm_pkg::UPDATE_IR:  state_nxt = tms_i ? dtm_pkg::SELECT_DR : dtm_pkg::RUN_IDLE;
            default:             state_nxt = dtm_pkg::TLR;
        endcase
    end

    // state only moves on a detected tck rise
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= dtm_pkg::TLR;
        end
        else if (tck_rise_i)
        begin
            state <= state_nxt;
        end
    end

    // strobes decode the state before the edge
    assign capture_dr_o = tck_rise_i && (state == dtm_pkg::CAPTURE_DR);
    assign shift_dr_o   = tck_rise_i && (state == dtm_pkg::SHIFT_DR);
    assign capture_ir_o = tck_rise_i && (state == dtm_pkg::CAPTURE_IR);
    assign shift_ir_o   = tck_rise_i && (state == dtm_pkg::SHIFT_IR);

    // update fires when an exit state is left with tms high
    assign update_dr_o = tck_rise_i && tms_i
                         && ((state == dtm_pkg::EXIT1_DR) || (state == dtm_pkg::EXIT2_DR));
    assign update_ir_o = tck_rise_i && tms_i
                         && ((state == dtm_pkg::EXIT1_IR) || (state == dtm_pkg::EXIT2_IR));

    // entry only, not every rise spent in tlr
    assign tlr_o = tck_rise_i && (state_nxt == dtm_pkg::TLR) && (state != dtm_pkg::TLR);

    // levels for the tdo side
    assign shifting_o = (state == dtm_pkg::SHIFT_DR) || (state == dtm_pkg::SHIFT_IR);
    assign ir_path_o  = (state == dtm_pkg::SHIFT_IR);

endmodule

`default_nettype wire

// File: src/tap_registers.sv
`timescale 1ns/1ps
`default_nettype none

module tap_registers #(
    parameter logic [31:0] ID_CODE = 32'h12345678
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               tck_fall_i,
    input  logic               tdi_i,
    input  logic               capture_dr_i,
    input  logic               shift_dr_i,
    input  logic               update_dr_i,
    input  logic               capture_ir_i,
    input  logic               shift_ir_i,
    input  logic               update_ir_i,
    input  logic               tlr_i,
    input  logic               shifting_i,
    input  logic               ir_path_i,
    input  dtm_pkg::dmi_word_u dmi_rd_word_i,
    output logic               tdo_o,
    output logic               dmi_update_o,
    output dtm_pkg::dmi_word_u dmi_wr_word_o
);

    // ir shift stage and the active instruction
    logic [dtm_pkg::IR_WIDTH-1:0] ir_sr;
    logic [dtm_pkg::IR_WIDTH-1:0] ir_q;

    // data register shift stages
    logic [31:0]        idcode_sr;
    logic               bypass_q;
    dtm_pkg::dmi_word_u dmi_sr;

    // lsb saved on shift, put on tdo at the following fall
    logic save_bit;
    logic save_pend;

    // dr path selection
    logic sel_idcode;
    logic sel_dmi;
    logic dr_lsb;
    logic out_bit;

    assign sel_idcode = (ir_q == dtm_pkg::INSTR_IDCODE);
    assign sel_dmi    = (ir_q == dtm_pkg::INSTR_DMI);

    // bypass covers INSTR_BYPASS and every unknown code
    always_comb
    begin
        if (sel_idcode)
        begin
            dr_lsb = idcode_sr[0];
        end
        else if (sel_dmi)
        begin
            dr_lsb = dmi_sr.raw[0];
        end
        else
        begin
            dr_lsb = bypass_q;
        end
    end

    assign out_bit = ir_path_i ? ir_sr[0] : dr_lsb;

    // instruction register
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ir_q <= dtm_pkg::INSTR_IDCODE;
        end
        else if (tlr_i)
        begin
            ir_q <= dtm_pkg::INSTR_IDCODE;
        end
        else if (update_ir_i)
        begin
            ir_q <= ir_sr;
        end
    end

    // shift stages, lsb out first, tdi in at msb
    always_ff @(posedge clk)
    begin
        if (capture_ir_i)
        begin
            ir_sr <= dtm_pkg::IR_CAPTURE;
        end
        else if (shift_ir_i)
        begin
            ir_sr <= {tdi_i, ir_sr[dtm_pkg::IR_WIDTH-1:1]};
        end

        if (capture_dr_i)
        begin
            idcode_sr <= ID_CODE;
            bypass_q  <= 1'b0;
            dmi_sr    <= dmi_rd_word_i;
        end
        else if (shift_dr_i)
        begin
            // only the selected path moves
            if (sel_idcode)
            begin
                idcode_sr <= {tdi_i, idcode_sr[31:1]};
            end
            else if (sel_dmi)
            begin
                dmi_sr.raw <= {tdi_i, dmi_sr.raw[dtm_pkg::DMI_WIDTH-1:1]};
            end
            else
            begin
                bypass_q <= tdi_i;
            end
        end

        if (shift_ir_i || shift_dr_i)
        begin
            save_bit <= out_bit;
        end
    end

    // tdo changes on the falling tck edge after each shift
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            save_pend <= 1'b0;
            tdo_o     <= 1'b0;
        end
        else
        begin
            if (shift_ir_i || shift_dr_i)
            begin
                save_pend <= 1'b1;
            end
            else if (tck_fall_i)
            begin
                save_pend <= 1'b0;
            end

            if (tck_fall_i && save_pend)
            begin
                tdo_o <= save_bit;
            end
            else if (tck_fall_i && !shifting_i)
            begin
                // park low outside the shift states
                tdo_o <= 1'b0;
            end
        end
    end

    // request side registers this, so a plain strobe is enough
    assign dmi_update_o  = update_dr_i && sel_dmi;
    assign dmi_wr_word_o = dmi_sr;

endmodule

`default_nettype wire

// File: src/dmi_request.sv
`timescale 1ns/1ps
`default_nettype none

module dmi_request (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      dmi_update_i,
    input  dtm_pkg::dmi_word_u        dmi_wr_word_i,
    input  logic                      ack_i,
    input  logic [31:0]               rdata_i,
    output dtm_pkg::dmi_word_u        dmi_rd_word_o,
    output logic                      rd_start_o,
    output logic                      wr_start_o,
    output logic [dtm_pkg::ABITS-1:0] addr_o,
    output logic [31:0]               wdata_o,
    output logic                      busy_o
);

    // stored dmi word, read back on the next capture
    dtm_pkg::dmi_word_u word_q;
    logic               busy_q;
    // outstanding request is a read
    logic               rd_pend;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            word_q     <= '0;
            busy_q     <= 1'b0;
            rd_pend    <= 1'b0;
            rd_start_o <= 1'b0;
            wr_start_o <= 1'b0;
        end
        else
        begin
            // starts are single cycle
            rd_start_o <= 1'b0;
            wr_start_o <= 1'b0;

            if (busy_q)
            begin
                // updates while busy are dropped
                if (ack_i)
                begin
                    busy_q  <= 1'b0;
                    rd_pend <= 1'b0;
                    if (rd_pend)
                    begin
                        word_q.f.addr <= addr_o;
                        word_q.f.data <= rdata_i;
                    end
                    word_q.f.op <= dtm_pkg::OP_SUCCESS;
                end
            end
            else if (dmi_update_i)
            begin
                word_q <= dmi_wr_word_i;
                case (dmi_wr_word_i.f.op)
                    dtm_pkg::OP_READ:
                    begin
                        rd_start_o <= 1'b1;
                        busy_q     <= 1'b1;
                        rd_pend    <= 1'b1;
                    end
                    dtm_pkg::OP_WRITE:
                    begin
                        wr_start_o <= 1'b1;
                        busy_q     <= 1'b1;
                        rd_pend    <= 1'b0;
                    end
                    default:
                    begin
                        // nop and reserved, nothing to start
                        rd_pend <= 1'b0;
                    end
                endcase
            end
        end
    end

    // bus side address and data, held until next accepted update
    always_ff @(posedge clk)
    begin
        if (dmi_update_i && !busy_q)
        begin
            addr_o  <= dmi_wr_word_i.f.addr;
            wdata_o <= dmi_wr_word_i.f.data;
        end
    end

    // capture sees busy status while a request is in flight
    always_comb
    begin
        dmi_rd_word_o = word_q;
        if (busy_q)
        begin
            dmi_rd_word_o.f.op = dtm_pkg::OP_BUSY;
        end
    end

    assign busy_o = busy_q;

endmodule

`default_nettype wire

// File: src/jtag_dtm_top.sv
`timescale 1ns/1ps
`default_nettype none

module jtag_dtm_top #(
    parameter logic [31:0] ID_CODE = dtm_pkg::IDCODE_VALUE
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      jtag_clk_i,
    input  logic                      jtag_tms_i,
    input  logic                      jtag_tdi_i,
    input  logic                      ack_i,
    input  logic [31:0]               rdata_i,
    output logic                      jtag_tdo_o,
    output logic                      rd_start_o,
    output logic                      wr_start_o,
    output logic [dtm_pkg::ABITS-1:0] addr_o,
    output logic [31:0]               wdata_o,
    output logic                      busy_o
);

    // synchronized pins and tck edge pulses
    logic tck_rise;
    logic tck_fall;
    logic tms;
    logic tdi;

    // tap strobes and levels
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic capture_ir;
    logic shift_ir;
    logic update_ir;
    logic tlr;
    logic shifting;
    logic ir_path;

    // dmi word exchange
    logic               dmi_update;
    dtm_pkg::dmi_word_u dmi_wr_word;
    dtm_pkg::dmi_word_u dmi_rd_word;

    jtag_sync u_sync (
        .clk        (clk),
        .rst_n      (rst_n),
        .jtag_clk_i (jtag_clk_i),
        .jtag_tms_i (jtag_tms_i),
        .jtag_tdi_i (jtag_tdi_i),
        .tck_rise_o (tck_rise),
        .tck_fall_o (tck_fall),
        .tms_o      (tms),
        .tdi_o      (tdi)
    );

    tap_controller u_tap (
        .clk          (clk),
        .rst_n        (rst_n),
        .tck_rise_i   (tck_rise),
        .tms_i        (tms),
        .capture_dr_o (capture_dr),
        .shift_dr_o   (shift_dr),
        .update_dr_o  (update_dr),
        .capture_ir_o (capture_ir),
        .shift_ir_o   (shift_ir),
        .update_ir_o  (update_ir),
        .tlr_o        (tlr),
        .shifting_o   (shifting),
        .ir_path_o    (ir_path)
    );

    tap_registers #(
        .ID_CODE (ID_CODE)
    ) u_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .tck_fall_i    (tck_fall),
        .tdi_i         (tdi),
        .capture_dr_i  (capture_dr),
        .shift_dr_i    (shift_dr),
        .update_dr_i   (update_dr),
        .capture_ir_i  (capture_ir),
        .shift_ir_i    (shift_ir),
        .update_ir_i   (update_ir),
        .tlr_i         (tlr),
        .shifting_i    (shifting),
        .ir_path_i     (ir_path),
        .dmi_rd_word_i (dmi_rd_word),
        .tdo_o         (jtag_tdo_o),
        .dmi_update_o  (dmi_update),
        .dmi_wr_word_o (dmi_wr_word)
    );

    dmi_request u_dmi (
        .clk           (clk),
        .rst_n         (rst_n),
        .dmi_update_i  (dmi_update),
        .dmi_wr_word_i (dmi_wr_word),
        .ack_i         (ack_i),
        .rdata_i       (rdata_i),
        .dmi_rd_word_o (dmi_rd_word),
        .rd_start_o    (rd_start_o),
        .wr_start_o    (wr_start_o),
        .addr_o        (addr_o),
        .wdata_o       (wdata_o),
        .busy_o        (busy_o)
    );

endmodule

`default_nettype wire

// File: tests/jtag_dtm_properties.sv
`timescale 1ns/1ps
`default_nettype none

module jtag_dtm_properties (
    input logic clk,
    input logic rst_n,
    input logic rd_start_i,
    input logic wr_start_i,
    input logic busy_i
);

    // read back by the testbench at the end of the run
    int unsigned fail_count = 0;

    // read and write start never together
    start_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_start_i && wr_start_i))
    else
    begin
        fail_count++;
        $error("read and write start high in the same cycle");
    end

    // starts are single cycle strobes
    rd_start_single: assert property (@(posedge clk) disable iff (!rst_n)
        rd_start_i |=> !rd_start_i)
    else
    begin
        fail_count++;
        $error("read start held longer than one cycle");
    end

    wr_start_single: assert property (@(posedge clk) disable iff (!rst_n)
        wr_start_i |=> !wr_start_i)
    else
    begin
        fail_count++;
        $error("write start held longer than one cycle");
    end

    // busy rises with the start, so it must have been low the cycle before
    no_start_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_start_i || wr_start_i) |-> !$past(busy_i))
    else
    begin
        fail_count++;
        $error("bus start issued while a request was outstanding");
    end

endmodule

bind dmi_request jtag_dtm_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_start_i (rd_start_o),
    .wr_start_i (wr_start_o),
    .busy_i     (busy_o)
);

`default_nettype wire

// File: tests/tb_jtag_dtm.sv
`timescale 1ns/1ps
`default_nettype none

module tb_jtag_dtm;

    // clk cycles per tck half period
    localparam int HALF_TCK = 8;
    // tck steps summed over all tests
    localparam int TOTAL_STEPS = 521;
    // clk cycles allowed for a bus request to finish
    localparam int IDLE_LIMIT = 64;
    localparam int DMI_PAD = 64 - dtm_pkg::DMI_WIDTH;

    logic                      clk;
    logic                      rst_n;
    logic                      jtag_clk;
    logic                      jtag_tms;
    logic                      jtag_tdi;
    logic                      ack;
    logic [31:0]               rdata;
    logic                      jtag_tdo;
    logic                      rd_start;
    logic                      wr_start;
    logic [dtm_pkg::ABITS-1:0] addr;
    logic [31:0]               wdata;
    logic                      busy;

    int unsigned checks = 0;
    int unsigned errors = 0;

    // bus side bookkeeping, filled by monitor and responder
    int unsigned               rd_count = 0;
    int unsigned               wr_count = 0;
    logic [dtm_pkg::ABITS-1:0] start_addr = '0;
    logic [31:0]               start_wdata = '0;
    logic [31:0]               last_rdata = '0;
    // responder holds ack back while set
    logic                      stall_ack;
    logic [31:0]               lcg_state = 32'd9;

    jtag_dtm_top #(
        .ID_CODE (dtm_pkg::IDCODE_VALUE)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .jtag_clk_i (jtag_clk),
        .jtag_tms_i (jtag_tms),
        .jtag_tdi_i (jtag_tdi),
        .ack_i      (ack),
        .rdata_i    (rdata),
        .jtag_tdo_o (jtag_tdo),
        .rd_start_o (rd_start),
        .wr_start_o (wr_start),
        .addr_o     (addr),
        .wdata_o    (wdata),
        .busy_o     (busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // count starts and keep what the bus saw
    always @(negedge clk)
    begin
        if (rst_n && rd_start)
        begin
            rd_count   = rd_count + 1;
            start_addr = addr;
        end
        if (rst_n && wr_start)
        begin
            wr_count    = wr_count + 1;
            start_addr  = addr;
            start_wdata = wdata;
        end
    end

    // bus responder, random latency of 1 to 8 cycles
    initial
    begin : responder
        int unsigned delay;
        ack   = 1'b0;
        rdata = '0;
        forever
        begin
            @(negedge clk);
            if (rst_n && (rd_start || wr_start))
            begin
                delay = 32'd1 + ((lcg_next() >> 16) & 32'd7);
                repeat (delay) @(negedge clk);
                while (stall_ack)
                begin
                    @(negedge clk);
                end
                ack        = 1'b1;
                rdata      = lcg_next();
                last_rdata = rdata;
                @(negedge clk);
                ack = 1'b0;
            end
        end
    end

    initial
    begin : watchdog
        repeat (TOTAL_STEPS * 2 * HALF_TCK * 2) @(posedge clk);
        $display("timeout: tests did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_dmi(input string name, input dtm_pkg::dmi_word_u got,
                             input dtm_pkg::dmi_word_u exp);
        checks++;
        if (got.raw !== exp.raw)
        begin
            errors++;
            $display("FAIL %s: got 0x%011h, expected 0x%011h", name, got.raw, exp.raw);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // one tck period, starting at a falling clk edge with tck low
    task automatic tck_step(input logic tms_bit, input logic tdi_bit, output logic tdo_bit);
        jtag_clk = 1'b0;
        jtag_tms = tms_bit;
        jtag_tdi = tdi_bit;
        repeat (HALF_TCK) @(negedge clk);
        // tdo is settled by the end of the low half
        tdo_bit  = jtag_tdo;
        jtag_clk = 1'b1;
        repeat (HALF_TCK) @(negedge clk);
    endtask

    // tms bits go out lsb first
    task automatic tms_seq(input logic [7:0] bits, input int count);
        logic tdo_bit;
        for (int i = 0; i < count; i++)
        begin
            tck_step(bits[i], 1'b0, tdo_bit);
        end
    endtask

    // shift state to run-idle, bit k of the capture shows up one tck after its shift
    task automatic shift_bits(input logic [63:0] bits_in, input int len,
                              output logic [63:0] bits_out);
        logic tdo_bit;
        bits_out = '0;
        for (int i = 0; i < len; i++)
        begin
            tck_step(i == len - 1, bits_in[i], tdo_bit);
            if (i > 0)
            begin
                bits_out[i-1] = tdo_bit;
            end
        end
        // exit1 to update
        tck_step(1'b1, 1'b0, tdo_bit);
        bits_out[len-1] = tdo_bit;
        tck_step(1'b0, 1'b0, tdo_bit);
    endtask

    task automatic shift_ir(input logic [dtm_pkg::IR_WIDTH-1:0] ir_in,
                            output logic [dtm_pkg::IR_WIDTH-1:0] ir_out);
        logic [63:0] bits_out;
        // select-dr, select-ir, capture-ir, shift-ir
        tms_seq(8'b0000_0011, 4);
        shift_bits({59'b0, ir_in}, dtm_pkg::IR_WIDTH, bits_out);
        ir_out = bits_out[dtm_pkg::IR_WIDTH-1:0];
    endtask

    task automatic shift_dr(input logic [63:0] dr_in, input int len,
                            output logic [63:0] dr_out);
        // select-dr, capture-dr, shift-dr
        tms_seq(8'b0000_0001, 3);
        shift_bits(dr_in, len, dr_out);
    endtask

    task automatic dmi_scan(input dtm_pkg::dmi_word_u w_in, output dtm_pkg::dmi_word_u w_out);
        logic [63:0] dr_out;
        shift_dr({{DMI_PAD{1'b0}}, w_in.raw}, dtm_pkg::DMI_WIDTH, dr_out);
        w_out.raw = dr_out[dtm_pkg::DMI_WIDTH-1:0];
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < IDLE_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (busy)
        begin
            errors++;
            $display("ERROR: bus request still busy after %0d clk cycles", IDLE_LIMIT);
        end
    endtask

    task automatic end_test(input string name, input int unsigned err_base);
        if (errors == err_base)
        begin
            $display("%s: ok", name);
        end
        else
        begin
            $display("%s: %0d errors", name, errors - err_base);
        end
    endtask

    task automatic test_idcode_after_reset();
        logic [63:0]                  dr_out;
        logic [dtm_pkg::IR_WIDTH-1:0] ir_out;
        // tlr to run-idle
        tms_seq(8'h00, 1);
        shift_dr(64'h0, 32, dr_out);
        check_word("jtag_tdo_o idcode", dr_out[31:0], dtm_pkg::IDCODE_VALUE);
        shift_ir(dtm_pkg::INSTR_IDCODE, ir_out);
        check_word("jtag_tdo_o ir capture", {27'b0, ir_out}, {27'b0, dtm_pkg::IR_CAPTURE});
    endtask

    task automatic bypass_pattern(input logic [dtm_pkg::IR_WIDTH-1:0] instr,
                                  input logic [15:0] pattern);
        logic [63:0]                  dr_out;
        logic [dtm_pkg::IR_WIDTH-1:0] ir_out;
        shift_ir(instr, ir_out);
        shift_dr({48'b0, pattern}, 16, dr_out);
        // single bypass stage, captured as zero
        check_bit("jtag_tdo_o first bypass bit", dr_out[0], 1'b0);
        check_word("jtag_tdo_o bypass", {16'b0, dr_out[15:0]}, {16'b0, pattern[14:0], 1'b0});
    endtask

    task automatic test_bypass();
        bypass_pattern(dtm_pkg::INSTR_BYPASS, 16'ha5c3);
        // unknown code falls back to bypass
        bypass_pattern(5'h05, 16'h3c96);
    endtask

    task automatic test_dmi_write();
        dtm_pkg::dmi_word_u           wr_word;
        dtm_pkg::dmi_word_u           nop_word;
        dtm_pkg::dmi_word_u           exp_word;
        dtm_pkg::dmi_word_u           got;
        logic [dtm_pkg::IR_WIDTH-1:0] ir_out;
        int unsigned                  rd_base;
        int unsigned                  wr_base;
        wr_word.raw    = '0;
        wr_word.f.addr = 10'h2a5;
        wr_word.f.data = 32'hdeadbeef;
        wr_word.f.op   = dtm_pkg::OP_WRITE;
        nop_word.raw   = '0;
        shift_ir(dtm_pkg::INSTR_DMI, ir_out);
        rd_base = rd_count;
        wr_base = wr_count;
        dmi_scan(wr_word, got);
        // stored word is still the reset value
        check_dmi("jtag_tdo_o first dmi capture", got, nop_word);
        check_word("wr_start_o count", wr_count - wr_base, 32'd1);
        check_word("rd_start_o count", rd_count - rd_base, 32'd0);
        check_word("addr_o", {22'b0, start_addr}, {22'b0, wr_word.f.addr});
        check_word("wdata_o", start_wdata, wr_word.f.data);
        wait_idle();
        dmi_scan(nop_word, got);
        exp_word      = wr_word;
        exp_word.f.op = dtm_pkg::OP_SUCCESS;
        check_dmi("jtag_tdo_o dmi after write", got, exp_word);
    endtask

    task automatic test_dmi_read();
        dtm_pkg::dmi_word_u rd_word;
        dtm_pkg::dmi_word_u nop_word;
        dtm_pkg::dmi_word_u exp_word;
        dtm_pkg::dmi_word_u got;
        int unsigned        rd_base;
        int unsigned        wr_base;
        rd_word.raw    = '0;
        rd_word.f.addr = 10'h13c;
        rd_word.f.op   = dtm_pkg::OP_READ;
        nop_word.raw   = '0;
        rd_base = rd_count;
        wr_base = wr_count;
        dmi_scan(rd_word, got);
        check_word("rd_start_o count", rd_count - rd_base, 32'd1);
        check_word("wr_start_o count", wr_count - wr_base, 32'd0);
        check_word("addr_o", {22'b0, start_addr}, {22'b0, rd_word.f.addr});
        wait_idle();
        dmi_scan(nop_word, got);
        exp_word.f.addr = rd_word.f.addr;
        exp_word.f.data = last_rdata;
        exp_word.f.op   = dtm_pkg::OP_SUCCESS;
        check_dmi("jtag_tdo_o dmi after read", got, exp_word);
    endtask

    task automatic test_dmi_busy();
        dtm_pkg::dmi_word_u rd_word;
        dtm_pkg::dmi_word_u wr_word;
        dtm_pkg::dmi_word_u nop_word;
        dtm_pkg::dmi_word_u exp_word;
        dtm_pkg::dmi_word_u got;
        int unsigned        rd_base;
        int unsigned        wr_base;
        rd_word.raw    = '0;
        rd_word.f.addr = 10'h0f1;
        rd_word.f.op   = dtm_pkg::OP_READ;
        wr_word.f.addr = 10'h155;
        wr_word.f.data = 32'h0badf00d;
        wr_word.f.op   = dtm_pkg::OP_WRITE;
        nop_word.raw   = '0;
        // read stays outstanding across the next whole scan
        stall_ack = 1'b1;
        rd_base = rd_count;
        wr_base = wr_count;
        dmi_scan(rd_word, got);
        dmi_scan(wr_word, got);
        exp_word      = rd_word;
        exp_word.f.op = dtm_pkg::OP_BUSY;
        check_dmi("jtag_tdo_o dmi while busy", got, exp_word);
        check_word("rd_start_o count", rd_count - rd_base, 32'd1);
        check_word("wr_start_o count", wr_count - wr_base, 32'd0);
        check_word("addr_o held", {22'b0, addr}, {22'b0, rd_word.f.addr});
        check_bit("busy_o", busy, 1'b1);
        stall_ack = 1'b0;
        wait_idle();
        // dropped write must not have touched the stored word
        dmi_scan(nop_word, got);
        exp_word.f.data = last_rdata;
        exp_word.f.op   = dtm_pkg::OP_SUCCESS;
        check_dmi("jtag_tdo_o dmi after busy read", got, exp_word);
    endtask

    task automatic test_tlr_escape();
        logic [63:0]                  dr_out;
        logic [dtm_pkg::IR_WIDTH-1:0] ir_out;
        shift_ir(dtm_pkg::INSTR_DMI, ir_out);
        // five tms highs reach tlr, ir falls back to idcode
        tms_seq(8'h1f, 5);
        tms_seq(8'h00, 1);
        shift_dr(64'h0, 32, dr_out);
        check_word("jtag_tdo_o idcode after tlr", dr_out[31:0], dtm_pkg::IDCODE_VALUE);
    endtask

    initial
    begin : main
        int unsigned err_base;
        rst_n     = 1'b0;
        jtag_clk  = 1'b0;
        jtag_tms  = 1'b1;
        jtag_tdi  = 1'b0;
        stall_ack = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        err_base = errors;
        test_idcode_after_reset();
        end_test("test 1 idcode after reset", err_base);
        err_base = errors;
        test_bypass();
        end_test("test 2 bypass", err_base);
        err_base = errors;
        test_dmi_write();
        end_test("test 3 dmi write", err_base);
        err_base = errors;
        test_dmi_read();
        end_test("test 4 dmi read", err_base);
        err_base = errors;
        test_dmi_busy();
        end_test("test 5 dmi busy", err_base);
        err_base = errors;
        test_tlr_escape();
        end_test("test 6 tlr escape", err_base);

        check_word("assertion failures", UUT.u_dmi.u_props.fail_count, 32'd0);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
src/dtm_pkg.sv
src/jtag_sync.sv
src/tap_controller.sv
src/tap_registers.sv
src/dmi_request.sv
src/jtag_dtm_top.sv
tests/jtag_dtm_properties.sv
tests/tb_jtag_dtm.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the jtag dtm testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_jtag_dtm -o tb_jtag_dtm_sim

# a crash or $stop still ends up in the grep below
out=$(./obj_dir/tb_jtag_dtm_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
else
    exit 1
fi
